// File: filelist.f
hw/cache_pkg.sv
hw/cache_lookup_if.sv
hw/cache_way_store.sv
hw/cache_controller.sv
hw/cache_top.sv
verification/cache_mem_model.sv
verification/cache_tb.sv

// File: hw/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller #(
    parameter int SET_BITS = 4
) (
    input  wire logic           clk_i,
    input  wire logic           rst_i,
    input  wire logic           read_i,
    input  wire logic           write_i,
    input  wire cache_pkg::word_t address_i,
    input  wire cache_pkg::word_t writedata_i,
    output cache_pkg::word_t    readdata_o,
    output logic                stb_o,
    output logic                busy_o,
    input  wire cache_pkg::word_t mem_readdata_i,
    input  wire logic           mem_ack_i,
    output cache_pkg::word_t    mem_address_o,
    output cache_pkg::word_t    mem_writedata_o,
    output logic                mem_read_o,
    output logic                mem_write_o,
    cache_lookup_if.ctrl        lookup
);
    import cache_pkg::*;

    localparam int TAG_BITS = XLEN - SET_BITS - OFFSET_BITS;

    cache_state_e state_q;

    // captured request
    word_t addr_q;
    word_t wdata_q;
    logic  is_read_q;

    // main-memory port registers
    word_t mem_address_q;
    word_t mem_writedata_q;
    logic  mem_read_q;
    logic  mem_write_q;

    word_t readdata_q;

    assign lookup.index = addr_q[OFFSET_BITS +: SET_BITS];
    assign lookup.tag   = addr_q[XLEN-1 -: TAG_BITS];

    // line writes and LRU touches for the current state
    always_comb begin
        lookup.wr_en    = 1'b0;
        lookup.wr_way   = lookup.victim_way;
        lookup.wr_data  = wdata_q;
        lookup.wr_dirty = 1'b1;
        lookup.touch_en = 1'b0;
        case (state_q)
            LOOKUP: begin
                if (lookup.hit) begin
                    lookup.wr_way = lookup.hit_way;
                    if (is_read_q) begin
                        lookup.touch_en = 1'b1;
                    end else begin
                        lookup.wr_en = 1'b1;
                    end
                end
            end
            FILL: begin
                if (is_read_q) begin
                    // clean fill when the memory word arrives
                    lookup.wr_en    = mem_ack_i;
                    lookup.wr_data  = mem_readdata_i;
                    lookup.wr_dirty = 1'b0;
                end else begin
                    lookup.wr_en = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= IDLE;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
            readdata_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (read_i || write_i) begin
                        addr_q    <= address_i;
                        wdata_q   <= writedata_i;
                        // read wins when both are raised
                        is_read_q <= read_i;
                        state_q   <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (lookup.hit) begin
                        readdata_q <= is_read_q ? lookup.hit_data : '0;
                        state_q    <= DONE;
                    end else if (lookup.victim_valid && lookup.victim_dirty) begin
                        mem_write_q     <= 1'b1;
                        mem_address_q   <= {lookup.victim_tag, lookup.index,
                                            {OFFSET_BITS{1'b0}}};
                        mem_writedata_q <= lookup.victim_data;
                        state_q         <= WRITEBACK;
                    end else begin
                        if (is_read_q) begin
                            mem_read_q    <= 1'b1;
                            mem_address_q <= addr_q;
                        end
                        state_q <= FILL;
                    end
                end
                WRITEBACK: begin
                    if (mem_ack_i) begin
                        mem_write_q <= 1'b0;
                        // write misses need no fetch after the write-back
                        if (is_read_q) begin
                            mem_read_q    <= 1'b1;
                            mem_address_q <= addr_q;
                        end
                        state_q <= FILL;
                    end
                end
                FILL: begin
                    if (!is_read_q) begin
                        readdata_q <= '0;
                        state_q    <= DONE;
                    end else if (mem_ack_i) begin
                        mem_read_q <= 1'b0;
                        readdata_q <= mem_readdata_i;
                        state_q    <= DONE;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign stb_o           = (state_q == DONE);
    assign busy_o          = (state_q != IDLE);
    assign readdata_o      = readdata_q;
    assign mem_address_o   = mem_address_q;
    assign mem_writedata_o = mem_writedata_q;
    assign mem_read_o      = mem_read_q;
    assign mem_write_o     = mem_write_q;

endmodule

`default_nettype wire

// File: hw/cache_lookup_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cache_lookup_if #(
    parameter int SET_BITS = 4
);
    import cache_pkg::*;

    localparam int TAG_BITS = XLEN - SET_BITS - OFFSET_BITS;

    // lookup key from the registered request
    logic [SET_BITS-1:0] index;
    logic [TAG_BITS-1:0] tag;

    // line write and LRU update requests
    logic                wr_en;
    way_e                wr_way;
    word_t               wr_data;
    logic                wr_dirty;
    logic                touch_en;

    // combinational lookup results
    logic                hit;
    way_e                hit_way;
    word_t               hit_data;
    way_e                victim_way;
    logic                victim_valid;
    logic                victim_dirty;
    logic [TAG_BITS-1:0] victim_tag;
    word_t               victim_data;

    modport store (
        input  index, tag, wr_en, wr_way, wr_data, wr_dirty, touch_en,
        output hit, hit_way, hit_data,
        output victim_way, victim_valid, victim_dirty, victim_tag, victim_data
    );

    modport ctrl (
        output index, tag, wr_en, wr_way, wr_data, wr_dirty, touch_en,
        input  hit, hit_way, hit_data,
        input  victim_way, victim_valid, victim_dirty, victim_tag, victim_data
    );

endinterface

`default_nettype wire

// File: hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // one cache line holds exactly one word
    localparam int XLEN = 32;

    // byte offset inside the word, below the set index
    localparam int OFFSET_BITS = 2;

    typedef logic [XLEN-1:0] word_t;

    // controller states
    // 5 states need a 3-bit encoding
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL,
        DONE
    } cache_state_e;

    // way select within a set
    typedef enum logic {
        WAY0 = 1'b0,
        WAY1 = 1'b1
    } way_e;

endpackage

`default_nettype wire

// File: hw/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int SET_BITS = 4
) (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire logic             read_i,
    input  wire logic             write_i,
    input  wire cache_pkg::word_t address_i,
    input  wire cache_pkg::word_t writedata_i,
    output cache_pkg::word_t      readdata_o,
    output logic                  stb_o,
    output logic                  busy_o,
    input  wire cache_pkg::word_t mem_readdata_i,
    input  wire logic             mem_ack_i,
    output cache_pkg::word_t      mem_address_o,
    output cache_pkg::word_t      mem_writedata_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o
);

    // lookup and line-write path between controller and storage
    cache_lookup_if #(.SET_BITS(SET_BITS)) lookup_if ();

    cache_controller #(
        .SET_BITS(SET_BITS)
    ) i_cache_controller (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .read_i         (read_i),
        .write_i        (write_i),
        .address_i      (address_i),
        .writedata_i    (writedata_i),
        .readdata_o     (readdata_o),
        .stb_o          (stb_o),
        .busy_o         (busy_o),
        .mem_readdata_i (mem_readdata_i),
        .mem_ack_i      (mem_ack_i),
        .mem_address_o  (mem_address_o),
        .mem_writedata_o(mem_writedata_o),
        .mem_read_o     (mem_read_o),
        .mem_write_o    (mem_write_o),
        .lookup         (lookup_if.ctrl)
    );

    cache_way_store #(
        .SET_BITS(SET_BITS)
    ) i_cache_way_store (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .lookup(lookup_if.store)
    );

endmodule

`default_nettype wire

// File: hw/cache_way_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way_store #(
    parameter int SET_BITS = 4
) (
    input  wire logic           clk_i,
    input  wire logic           rst_i,
    cache_lookup_if.store       lookup
);
    import cache_pkg::*;

    localparam int TAG_BITS = XLEN - SET_BITS - OFFSET_BITS;
    localparam int SETS     = 1 << SET_BITS;

    // line state indexed by way then set
    logic [SETS-1:0]     valid_q [2];
    logic [SETS-1:0]     dirty_q [2];
    logic [TAG_BITS-1:0] tag_q   [2][SETS];
    word_t               data_q  [2][SETS];

    // the way to replace next in each set when both ways are valid
    logic [SETS-1:0]     lru_q;

    logic                way_hit [2];
    way_e                victim;

    // tag compare on both ways
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][lookup.index] &&
                         (tag_q[w][lookup.index] == lookup.tag);
        end
    end

    assign lookup.hit      = way_hit[0] | way_hit[1];
    assign lookup.hit_way  = way_hit[1] ? WAY1 : WAY0;
    assign lookup.hit_data = data_q[lookup.hit_way][lookup.index];

    // an empty way is always taken before an old one
    always_comb begin
        if (!valid_q[0][lookup.index]) begin
            victim = WAY0;
        end else if (!valid_q[1][lookup.index]) begin
            victim = WAY1;
        end else begin
            victim = way_e'(lru_q[lookup.index]);
        end
    end

    assign lookup.victim_way   = victim;
    assign lookup.victim_valid = valid_q[victim][lookup.index];
    assign lookup.victim_dirty = dirty_q[victim][lookup.index];
    assign lookup.victim_tag   = tag_q[victim][lookup.index];
    assign lookup.victim_data  = data_q[victim][lookup.index];

    // valid, dirty and replacement order bits
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            lru_q      <= '0;
        end else if (lookup.wr_en) begin
            valid_q[lookup.wr_way][lookup.index] <= 1'b1;
            dirty_q[lookup.wr_way][lookup.index] <= lookup.wr_dirty;
            // the written way becomes most recent and the other one goes next
            lru_q[lookup.index]                  <= ~lookup.wr_way;
        end else if (lookup.touch_en) begin
            lru_q[lookup.index] <= ~lookup.hit_way;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk_i) begin
        if (lookup.wr_en) begin
            tag_q[lookup.wr_way][lookup.index]  <= lookup.tag;
            data_q[lookup.wr_way][lookup.index] <= lookup.wr_data;
        end
    end

endmodule

`default_nettype wire

// File: verification/cache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module cache_mem_model (
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic        mem_read_i,
    input  wire logic        mem_write_i,
    input  wire logic [31:0] mem_address_i,
    input  wire logic [31:0] mem_writedata_i,
    output logic      [31:0] mem_readdata_o,
    output logic             mem_ack_o
);
    // 256 words addressed by word index
    logic [31:0] mem_q [256];
    logic [31:0] rand_q;
    logic [31:0] rand_next;
    logic [1:0]  wait_q;
    logic        pending_q;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign rand_next = next_rand(rand_q);

    initial begin
        rand_q         = 32'd3;
        mem_ack_o      = 1'b0;
        mem_readdata_o = '0;
        for (int i = 0; i < 256; i++) begin
            mem_q[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        end
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            mem_ack_o <= 1'b0;
            pending_q <= 1'b0;
        end else if (mem_ack_o) begin
            // request drops on the edge that samples the ack
            mem_ack_o <= 1'b0;
        end else if (pending_q && wait_q == 2'd0) begin
            mem_ack_o <= 1'b1;
            pending_q <= 1'b0;
            if (mem_write_i) begin
                mem_q[mem_address_i[9:2]] <= mem_writedata_i;
            end else begin
                mem_readdata_o <= mem_q[mem_address_i[9:2]];
            end
        end else if (pending_q) begin
            wait_q <= wait_q - 2'd1;
        end else if (mem_read_i || mem_write_i) begin
            // ack comes 1 to 4 cycles after the request is seen
            rand_q    <= rand_next;
            wait_q    <= rand_next[17:16];
            pending_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verification/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int SET_BITS     = 4;
    localparam int SETS         = 1 << SET_BITS;
    localparam int TAG_BITS     = XLEN - SET_BITS - OFFSET_BITS;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 200;
    // two directed requests run before the random ones
    localparam int NUM_REQUESTS = NUM_RANDOM + 2;

    logic  clk_i, rst_i, read_i, write_i, stb_o, busy_o;
    logic  mem_ack_i, mem_read_o, mem_write_o;
    word_t address_i, writedata_i, readdata_o;
    word_t mem_readdata_i, mem_address_o, mem_writedata_o;

    // reference model with the latest value per memory word and line state per set
    word_t               shadow [256];
    bit                  ref_valid [2][SETS];
    bit                  ref_dirty [2][SETS];
    logic [TAG_BITS-1:0] ref_tag [2][SETS];
    bit                  ref_lru [SETS];
    word_t               rand_state;

    cache_top #(.SET_BITS(SET_BITS)) i_cache_top (.*);

    cache_mem_model i_cache_mem_model (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .mem_read_i     (mem_read_o),
        .mem_write_i    (mem_write_o),
        .mem_address_i  (mem_address_o),
        .mem_writedata_i(mem_writedata_o),
        .mem_readdata_o (mem_readdata_i),
        .mem_ack_o      (mem_ack_i)
    );

    function automatic word_t fill_word(input int idx);
        return {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5a, 8'hc3};
    endfunction

    function automatic word_t next_rand(input word_t s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (expected === actual) else begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // one request from the drive point after an edge to the edge that samples stb_o
    task automatic run_request(input bit is_read, input word_t a, input word_t d);
        logic [SET_BITS-1:0] set;
        logic [TAG_BITS-1:0] tag;
        bit                  hit;
        bit                  victim_dirty;
        bit                  first_is_wr;
        bit                  prev_rd;
        bit                  prev_wr;
        int                  hit_way;
        int                  victim;
        int                  cycles;
        int                  n_rd;
        int                  n_wr;
        word_t               victim_addr;
        word_t               wb_addr;
        word_t               wb_data;
        word_t               rd_addr;
        set = a[OFFSET_BITS +: SET_BITS];
        tag = a[XLEN-1 -: TAG_BITS];
        hit = 1'b0;
        hit_way = 0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][set] && ref_tag[w][set] == tag) begin
                hit = 1'b1;
                hit_way = w;
            end
        end
        // an empty way goes first and then the least recently used one
        if (!ref_valid[0][set]) begin
            victim = 0;
        end else if (!ref_valid[1][set]) begin
            victim = 1;
        end else begin
            victim = ref_lru[set];
        end
        victim_dirty = ref_valid[victim][set] && ref_dirty[victim][set];
        victim_addr  = {ref_tag[victim][set], set, {OFFSET_BITS{1'b0}}};

        read_i      = is_read;
        write_i     = !is_read;
        address_i   = a;
        writedata_i = d;
        @(posedge clk_i);
        #1;
        // scramble the inputs once the request is captured
        read_i      = 1'b0;
        write_i     = 1'b0;
        address_i   = ~a;
        writedata_i = ~d;
        cycles = 0;
        n_rd = 0;
        n_wr = 0;
        first_is_wr = 1'b0;
        prev_rd = 1'b0;
        prev_wr = 1'b0;
        do begin
            @(posedge clk_i);
            cycles++;
            if (mem_write_o && !prev_wr) begin
                first_is_wr = (n_rd + n_wr == 0);
                n_wr++;
                wb_addr = mem_address_o;
                wb_data = mem_writedata_o;
            end
            if (mem_read_o && !prev_rd) begin
                n_rd++;
                rd_addr = mem_address_o;
            end
            prev_rd = mem_read_o;
            prev_wr = mem_write_o;
        end while (!stb_o);

        check_value("read_data", is_read ? shadow[a[9:2]] : '0, readdata_o);
        if (hit) begin
            check_value("hit_latency", 2, cycles);
            check_value("hit_latency", 0, n_rd + n_wr);
        end else if (victim_dirty) begin
            check_value("writeback_order", 1, first_is_wr);
            check_value("writeback_order", 1, n_wr);
            check_value("writeback_order", victim_addr, wb_addr);
            check_value("writeback_order", shadow[victim_addr[9:2]], wb_data);
            check_value("writeback_order", is_read ? 1 : 0, n_rd);
            if (is_read) begin
                check_value("writeback_order", a, rd_addr);
            end
        end else if (is_read) begin
            check_value("clean_miss", 0, n_wr);
            check_value("clean_miss", 1, n_rd);
            check_value("clean_miss", a, rd_addr);
        end else begin
            check_value("write_allocate", 0, n_rd + n_wr);
        end

        if (!is_read) begin
            shadow[a[9:2]] = d;
        end
        if (hit) begin
            ref_dirty[hit_way][set] = ref_dirty[hit_way][set] || !is_read;
            ref_lru[set] = (hit_way == 0);
        end else begin
            ref_valid[victim][set] = 1'b1;
            ref_dirty[victim][set] = !is_read;
            ref_tag[victim][set]   = tag;
            ref_lru[set]           = (victim == 0);
        end
        #1;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        #((RESET_CYCLES + 4 + NUM_REQUESTS * 20) * 4);
        $display("timeout: the requests did not all complete within the cycle bound");
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        word_t a;
        bit    op_read;
        rst_i       = 1'b1;
        read_i      = 1'b0;
        write_i     = 1'b0;
        address_i   = '0;
        writedata_i = '0;
        rand_state  = 32'd3;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fill_word(i);
        end
        // outputs are unknown until the first reset edge
        for (int n = 0; n < RESET_CYCLES; n++) begin
            @(posedge clk_i);
            if (n > 0) begin
                check_value("reset_idle", 0, {stb_o, busy_o, mem_read_o, mem_write_o});
            end
        end
        #1;
        rst_i = 1'b0;
        @(posedge clk_i);
        #1;
        // state after the first edge out of reset
        check_value("reset_idle", 0, {stb_o, busy_o, mem_read_o, mem_write_o});

        // write miss into an empty set and then a read hit on it
        run_request(1'b0, 32'h0000_015c, 32'h1234_abcd);
        run_request(1'b1, 32'h0000_015c, 32'h0);

        // three sets and four tags each so that hits and evictions both occur
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rand_state = next_rand(rand_state);
            a = (word_t'(rand_state[21:20]) << 6) | (word_t'(rand_state[19:16] % 3) << 2);
            op_read = rand_state[24];
            rand_state = next_rand(rand_state);
            run_request(op_read, a, rand_state);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
